// ==== include/pong_defs.svh ====
// ============================================================
// global constants for the wall game display core
// screen timing, walls, ball, racket, speed and colours
// ============================================================
`ifndef PONG_DEFS_SVH
`define PONG_DEFS_SVH

// 1024x768 timing, sync pulses active low
`define H_VISIBLE 1024
`define H_FRONT   24
`define H_SYNC    136
`define H_TOTAL   1344
`define V_VISIBLE 768
`define V_FRONT   3
`define V_SYNC    6
`define V_TOTAL   806

`define LEFT_WALL  1
`define RIGHT_WALL 1022
`define UP_WALL    1
`define DOWN_WALL  766

// ball start column, also where the net is drawn
`define BALL_DIAMETER 16
`define BALL_RADIUS   8
`define CENTRAL_LINE  611

`define RACKET_XPOS   60
`define RACKET_WIDTH  10
`define RACKET_LENGTH 80

`define MAX_SPEED_STEPS   9
`define STEPS_PER_HALVING 5

// step intervals in pclk cycles, 2^19, 2^15 and 2^7
`define INTERVAL_START       524288
`define INTERVAL_CHANGE_HARD 32768
`define INTERVAL_CHANGE_EASY 128

`define COLOR_BALL   12'hff0
`define COLOR_RACKET 12'h0f0
`define COLOR_NET    12'h888
`define COLOR_BACK   12'h014

`endif

// ==== design/pong_pkg.sv ====
// ============================================================
// shared types: screen coordinate, ball position,
// ball direction, raster state and pixel colour
// ============================================================
package pong_pkg;

  typedef logic [11:0] coord_t;

  typedef struct packed {
    coord_t xpos;
    coord_t ypos;
  } ball_pos_t;

  // diagonal directions only
  typedef enum logic [1:0] {
    up_right   = 2'b00,
    down_right = 2'b01,
    down_left  = 2'b10,
    up_left    = 2'b11
  } ball_dir_t;

  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   blank;
  } raster_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

endpackage

// ==== design/ball_ctl.sv ====
// ============================================================
// ball controller: idle tracking of the mouse, diagonal
// motion, wall and racket bounces, speed-up on wall hits
// ============================================================
`timescale 1ns/1ps
`include "pong_defs.svh"

module ball_ctl
  import pong_pkg::*;
#(
  parameter int unsigned interval_start       = `INTERVAL_START,
  parameter int unsigned interval_change_easy = `INTERVAL_CHANGE_EASY,
  parameter int unsigned interval_change_hard = `INTERVAL_CHANGE_HARD
) (
  input  logic      pclk,
  input  logic      rst,
  input  coord_t    mouse_ypos,
  input  logic      mouse_left,
  input  logic      difficulty,
  output ball_pos_t ball_pos
);

  typedef enum logic {
    idle,
    moving
  } state_t;

  state_t      state, state_nxt;
  ball_dir_t   dir, dir_nxt;
  ball_pos_t   ball_pos_nxt;
  logic [19:0] interval_count, interval_count_nxt;
  logic [19:0] pxl_interval, pxl_interval_nxt;
  logic [19:0] interval_change, interval_change_nxt;
  logic [3:0]  speed_count, speed_count_nxt;
  logic [2:0]  speed_change_count, speed_change_count_nxt;
  logic        going_down, going_right;
  logic        wall_hit, vert_touch, horiz_touch, racket_hit;
  logic [12:0] ball_bottom, racket_bottom;

  function automatic ball_dir_t make_dir(input logic down, input logic right);
    ball_dir_t d;
    case ({down, right})
      2'b01:   d = up_right;
      2'b11:   d = down_right;
      2'b10:   d = down_left;
      default: d = up_left;
    endcase
    return d;
  endfunction

  assign going_down  = (dir == down_right) || (dir == down_left);
  assign going_right = (dir == up_right) || (dir == down_right);

  // any wall within reach of the ball
  assign wall_hit = (ball_pos.ypos >= `DOWN_WALL - `BALL_DIAMETER) ||
                    (ball_pos.ypos <= `UP_WALL) ||
                    (ball_pos.xpos >= `RIGHT_WALL - `BALL_DIAMETER) ||
                    (ball_pos.xpos <= `LEFT_WALL);

  // only walls in the direction of travel flip it, vertical first
  assign vert_touch  = going_down ? (ball_pos.ypos >= `DOWN_WALL - `BALL_DIAMETER)
                                  : (ball_pos.ypos <= `UP_WALL);
  assign horiz_touch = going_right ? (ball_pos.xpos >= `RIGHT_WALL - `BALL_DIAMETER)
                                   : (ball_pos.xpos <= `LEFT_WALL);

  // racket span, 13 bits so nothing wraps near the screen edges
  assign ball_bottom   = {1'b0, ball_pos.ypos} + 13'(`BALL_DIAMETER);
  assign racket_bottom = {1'b0, mouse_ypos} + 13'(`RACKET_LENGTH);
  assign racket_hit    = (ball_pos.xpos == coord_t'(`RACKET_XPOS)) &&
                         (ball_bottom >= {1'b0, mouse_ypos}) &&
                         ({1'b0, ball_pos.ypos} <= racket_bottom);

  // a click toggles between idle and moving
  always_comb begin
    state_nxt = state;
    case (state)
      idle:    if (mouse_left) state_nxt = moving;
      moving:  if (mouse_left) state_nxt = idle;
      default: state_nxt = idle;
    endcase
  end

  always_comb begin
    ball_pos_nxt           = ball_pos;
    dir_nxt                = dir;
    interval_count_nxt     = interval_count;
    pxl_interval_nxt       = pxl_interval;
    interval_change_nxt    = interval_change;
    speed_count_nxt        = speed_count;
    speed_change_count_nxt = speed_change_count;

    if (state_nxt == idle) begin
      // ball waits on the net column at mouse height
      ball_pos_nxt.xpos      = coord_t'(`CENTRAL_LINE);
      ball_pos_nxt.ypos      = mouse_ypos;
      dir_nxt                = up_left;
      interval_count_nxt     = '0;
      pxl_interval_nxt       = 20'(interval_start);
      interval_change_nxt    = difficulty ? 20'(interval_change_hard)
                                          : 20'(interval_change_easy);
      speed_count_nxt        = '0;
      speed_change_count_nxt = '0;
    end else if (interval_count != pxl_interval) begin
      interval_count_nxt = interval_count + 20'd1;
    end else begin
      // one diagonal pixel step
      interval_count_nxt = '0;
      ball_pos_nxt.xpos  = going_right ? ball_pos.xpos + 12'd1 : ball_pos.xpos - 12'd1;
      ball_pos_nxt.ypos  = going_down ? ball_pos.ypos + 12'd1 : ball_pos.ypos - 12'd1;

      if (wall_hit) begin
        if (vert_touch) begin
          dir_nxt = make_dir(!going_down, going_right);
        end else if (horiz_touch) begin
          dir_nxt = make_dir(going_down, !going_right);
        end

        if (speed_count < `MAX_SPEED_STEPS) begin
          // floor at zero, then the ball steps every cycle
          pxl_interval_nxt = (pxl_interval > interval_change) ?
                             pxl_interval - interval_change : '0;
          if (speed_change_count == 3'(`STEPS_PER_HALVING - 1)) begin
            speed_change_count_nxt = '0;
            speed_count_nxt        = speed_count + 4'd1;
            interval_change_nxt    = interval_change >> 1;
          end else begin
            speed_change_count_nxt = speed_change_count + 3'd1;
          end
        end
      end else if (racket_hit && !going_right) begin
        dir_nxt = make_dir(going_down, 1'b1);
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      state              <= idle;
      dir                <= up_right;
      ball_pos           <= '0;
      interval_count     <= '0;
      pxl_interval       <= '0;
      interval_change    <= '0;
      speed_count        <= '0;
      speed_change_count <= '0;
    end else begin
      state              <= state_nxt;
      dir                <= dir_nxt;
      ball_pos           <= ball_pos_nxt;
      interval_count     <= interval_count_nxt;
      pxl_interval       <= pxl_interval_nxt;
      interval_change    <= interval_change_nxt;
      speed_count        <= speed_count_nxt;
      speed_change_count <= speed_change_count_nxt;
    end
  end

  // bounces keep the ball within one pixel of the side walls
  a_xpos_in_field: assert property (@(posedge pclk) disable iff (rst)
    (state == moving) |-> (ball_pos.xpos >= `LEFT_WALL - 1) &&
                          (ball_pos.xpos <= `RIGHT_WALL))
    else $error("ball xpos %0d outside the field", ball_pos.xpos);

  // the game only ever gets faster while running
  a_interval_no_rise: assert property (@(posedge pclk) disable iff (rst)
    (state == moving) ##1 (state == moving) |-> pxl_interval <= $past(pxl_interval))
    else $error("step interval rose to %0d", pxl_interval);

endmodule

// ==== design/vga_timing.sv ====
// ============================================================
// 1024x768 raster timing: pixel and line counters,
// active low syncs and blank flag
// ============================================================
`timescale 1ns/1ps
`include "pong_defs.svh"

module vga_timing
  import pong_pkg::*;
(
  input  logic    pclk,
  input  logic    rst,
  output raster_t raster
);

  coord_t hcount_nxt, vcount_nxt;
  logic   hsync_nxt, vsync_nxt, blank_nxt;

  always_comb begin
    hcount_nxt = raster.hcount + 12'd1;
    vcount_nxt = raster.vcount;
    if (raster.hcount == coord_t'(`H_TOTAL - 1)) begin
      hcount_nxt = '0;
      // end of line, move down a row
      if (raster.vcount == coord_t'(`V_TOTAL - 1)) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = raster.vcount + 12'd1;
      end
    end
  end

  // flags from the next counts so they line up with them
  assign hsync_nxt = !((hcount_nxt >= `H_VISIBLE + `H_FRONT) &&
                       (hcount_nxt < `H_VISIBLE + `H_FRONT + `H_SYNC));
  assign vsync_nxt = !((vcount_nxt >= `V_VISIBLE + `V_FRONT) &&
                       (vcount_nxt < `V_VISIBLE + `V_FRONT + `V_SYNC));
  assign blank_nxt = (hcount_nxt >= `H_VISIBLE) || (vcount_nxt >= `V_VISIBLE);

  always_ff @(posedge pclk) begin
    if (rst) begin
      // pixel 0,0 with syncs inactive
      raster.hcount <= '0;
      raster.vcount <= '0;
      raster.hsync  <= 1'b1;
      raster.vsync  <= 1'b1;
      raster.blank  <= 1'b0;
    end else begin
      raster.hcount <= hcount_nxt;
      raster.vcount <= vcount_nxt;
      raster.hsync  <= hsync_nxt;
      raster.vsync  <= vsync_nxt;
      raster.blank  <= blank_nxt;
    end
  end

  a_counts_in_range: assert property (@(posedge pclk) disable iff (rst)
    (raster.hcount < `H_TOTAL) && (raster.vcount < `V_TOTAL))
    else $error("raster counts out of range %0d,%0d", raster.hcount, raster.vcount);

endmodule

// ==== design/pixel_render.sv ====
// ============================================================
// pixel renderer: ball disc, racket, net and background
// from the raster position, registered colour and syncs
// ============================================================
`timescale 1ns/1ps
`include "pong_defs.svh"

module pixel_render
  import pong_pkg::*;
(
  input  logic      pclk,
  input  logic      rst,
  input  raster_t   raster,
  input  ball_pos_t ball_pos,
  input  coord_t    mouse_ypos,
  output rgb_t      rgb,
  output logic      hsync,
  output logic      vsync
);

  logic signed [12:0] dx, dy;
  logic signed [25:0] dx2, dy2;
  logic [26:0]        dist2;
  logic [12:0]        racket_end;
  logic               in_ball, in_racket, on_net;
  rgb_t               rgb_nxt;

  // offsets from the ball centre
  assign dx    = $signed({1'b0, raster.hcount}) - $signed({1'b0, ball_pos.xpos}) -
                 13'sd`BALL_RADIUS;
  assign dy    = $signed({1'b0, raster.vcount}) - $signed({1'b0, ball_pos.ypos}) -
                 13'sd`BALL_RADIUS;
  assign dx2   = dx * dx;
  assign dy2   = dy * dy;
  assign dist2 = 27'(dx2) + 27'(dy2);

  assign in_ball = dist2 <= 27'(`BALL_RADIUS * `BALL_RADIUS);

  // racket sits just left of the bounce column
  assign racket_end = {1'b0, mouse_ypos} + 13'(`RACKET_LENGTH);
  assign in_racket  = (raster.hcount >= `RACKET_XPOS - `RACKET_WIDTH) &&
                      (raster.hcount < `RACKET_XPOS) &&
                      (raster.vcount >= mouse_ypos) &&
                      ({1'b0, raster.vcount} < racket_end);

  assign on_net = raster.hcount == coord_t'(`CENTRAL_LINE);

  // highest priority first
  always_comb begin
    if (raster.blank) begin
      rgb_nxt = '0;
    end else if (in_ball) begin
      rgb_nxt = rgb_t'(`COLOR_BALL);
    end else if (in_racket) begin
      rgb_nxt = rgb_t'(`COLOR_RACKET);
    end else if (on_net) begin
      rgb_nxt = rgb_t'(`COLOR_NET);
    end else begin
      rgb_nxt = rgb_t'(`COLOR_BACK);
    end
  end

  // syncs delayed with the colour
  always_ff @(posedge pclk) begin
    if (rst) begin
      rgb   <= '0;
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      rgb   <= rgb_nxt;
      hsync <= raster.hsync;
      vsync <= raster.vsync;
    end
  end

  a_black_in_blank: assert property (@(posedge pclk) disable iff (rst)
    raster.blank |=> (rgb == '0))
    else $error("colour %h driven during blanking", rgb);

endmodule

// ==== design/pong_top.sv ====
// ============================================================
// display core top: ball controller, raster timing
// and pixel renderer
// ============================================================
`timescale 1ns/1ps
`include "pong_defs.svh"

module pong_top
  import pong_pkg::*;
#(
  parameter int unsigned interval_start       = `INTERVAL_START,
  parameter int unsigned interval_change_easy = `INTERVAL_CHANGE_EASY,
  parameter int unsigned interval_change_hard = `INTERVAL_CHANGE_HARD
) (
  input  logic      pclk,
  input  logic      rst,
  input  coord_t    mouse_ypos,
  input  logic      mouse_left,
  input  logic      difficulty,
  output rgb_t      rgb,
  output logic      hsync,
  output logic      vsync,
  output ball_pos_t ball_pos
);

  raster_t raster;

  // ball position also leaves the core for game logic
  ball_ctl #(
    .interval_start       (interval_start),
    .interval_change_easy (interval_change_easy),
    .interval_change_hard (interval_change_hard)
  ) ball_ctl_i (
    .pclk       (pclk),
    .rst        (rst),
    .mouse_ypos (mouse_ypos),
    .mouse_left (mouse_left),
    .difficulty (difficulty),
    .ball_pos   (ball_pos)
  );

  vga_timing vga_timing_i (
    .pclk   (pclk),
    .rst    (rst),
    .raster (raster)
  );

  pixel_render pixel_render_i (
    .pclk       (pclk),
    .rst        (rst),
    .raster     (raster),
    .ball_pos   (ball_pos),
    .mouse_ypos (mouse_ypos),
    .rgb        (rgb),
    .hsync      (hsync),
    .vsync      (vsync)
  );

endmodule

// ==== sim/pong_tb.sv ====
// ============================================================
// testbench for the display core: reference ball model,
// raster mirror, pixel colour model and per-cycle compare
// ============================================================
`timescale 1ns/1ps
`include "pong_defs.svh"

module pong_tb
  import pong_pkg::*;
();

  localparam int start_interval = 64;
  localparam int easy_change    = 2;
  localparam int hard_change    = 8;
  localparam int wait_limit     = 1000000;
  localparam int sel_x          = 0;
  localparam int sel_y          = 1;
  localparam int sel_speed      = 2;
  localparam int sel_run        = 3;

  typedef struct packed {
    logic        moving;
    logic        down;
    logic        right;
    coord_t      x;
    coord_t      y;
    logic [19:0] count;
    logic [19:0] interval;
    logic [19:0] change;
    logic [3:0]  speed;
    logic [2:0]  drops;
  } model_t;

  logic      pclk;
  logic      rst;
  logic      mouse_left;
  logic      difficulty;
  coord_t    mouse_ypos;
  rgb_t      rgb;
  logic      hsync;
  logic      vsync;
  ball_pos_t ball_pos;

  model_t      ref_ball;
  int          hc;
  int          vc;
  logic [11:0] exp_rgb;
  logic        exp_hsync;
  logic        exp_vsync;
  logic        armed;
  int          n_ball;
  int          n_racket;
  int          n_net;
  int          track_mode;
  integer      seed;
  coord_t      y_set;
  int          i;

  pong_top #(
    .interval_start       (start_interval),
    .interval_change_easy (easy_change),
    .interval_change_hard (hard_change)
  ) dut_i (
    .pclk       (pclk),
    .rst        (rst),
    .mouse_ypos (mouse_ypos),
    .mouse_left (mouse_left),
    .difficulty (difficulty),
    .rgb        (rgb),
    .hsync      (hsync),
    .vsync      (vsync),
    .ball_pos   (ball_pos)
  );

  always #10 pclk = ~pclk;

  // next ball state after one clock edge
  function automatic model_t next_ball(model_t m, int my, logic click, logic diff);
    model_t n;
    int     xi;
    int     yi;
    logic   wall;
    logic   flip_v;
    logic   flip_h;
    n      = m;
    xi     = m.x;
    yi     = m.y;
    n.moving = m.moving ^ click;
    if (!n.moving) begin
      n.x        = coord_t'(`CENTRAL_LINE);
      n.y        = coord_t'(my);
      n.down     = 1'b0;
      n.right    = 1'b0;
      n.count    = '0;
      n.interval = 20'(start_interval);
      n.change   = diff ? 20'(hard_change) : 20'(easy_change);
      n.speed    = '0;
      n.drops    = '0;
    end else if (m.count != m.interval) begin
      n.count = m.count + 20'd1;
    end else begin
      n.count = '0;
      n.x     = m.right ? coord_t'(xi + 1) : coord_t'(xi - 1);
      n.y     = m.down ? coord_t'(yi + 1) : coord_t'(yi - 1);
      wall    = (yi >= `DOWN_WALL - `BALL_DIAMETER) || (yi <= `UP_WALL) ||
                (xi >= `RIGHT_WALL - `BALL_DIAMETER) || (xi <= `LEFT_WALL);
      flip_v  = m.down ? (yi >= `DOWN_WALL - `BALL_DIAMETER) : (yi <= `UP_WALL);
      flip_h  = m.right ? (xi >= `RIGHT_WALL - `BALL_DIAMETER) : (xi <= `LEFT_WALL);
      if (wall) begin
        if (flip_v) begin
          n.down = !m.down;
        end else if (flip_h) begin
          n.right = !m.right;
        end
        if (m.speed < `MAX_SPEED_STEPS) begin
          n.interval = (m.interval > m.change) ? m.interval - m.change : '0;
          n.drops    = m.drops + 3'd1;
          if (n.drops == `STEPS_PER_HALVING) begin
            n.drops  = '0;
            n.speed  = m.speed + 4'd1;
            n.change = m.change >> 1;
          end
        end
      end else if (!m.right && xi == `RACKET_XPOS && yi + `BALL_DIAMETER >= my &&
                   yi <= my + `RACKET_LENGTH) begin
        n.right = 1'b1;
      end
    end
    return n;
  endfunction

  // expected colour of one raster position
  function automatic logic [11:0] pixel_color(int h, int v, int bx, int by, int my);
    int dx;
    int dy;
    dx = h - bx - `BALL_RADIUS;
    dy = v - by - `BALL_RADIUS;
    if (h >= `H_VISIBLE || v >= `V_VISIBLE) return 12'h000;
    if (dx * dx + dy * dy <= `BALL_RADIUS * `BALL_RADIUS) return `COLOR_BALL;
    if (h >= `RACKET_XPOS - `RACKET_WIDTH && h < `RACKET_XPOS && v >= my &&
        v < my + `RACKET_LENGTH) return `COLOR_RACKET;
    if (h == `CENTRAL_LINE) return `COLOR_NET;
    return `COLOR_BACK;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("error %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // polls once per falling edge until the condition holds
  task automatic wait_until(input int sel, input int target, input int limit,
                            input string what);
    int        n;
    int        run;
    ball_pos_t prev;
    logic      done;
    n    = 0;
    run  = 0;
    prev = ball_pos;
    done = 1'b0;
    while (!done) begin
      case (sel)
        sel_x:     done = (ball_pos.xpos == target);
        sel_y:     done = (ball_pos.ypos == target);
        sel_speed: done = (ref_ball.speed == target);
        default:   done = (run >= target);
      endcase
      if (!done) begin
        if (n == limit) report_failure($sformatf("timeout waiting for %s", what));
        @(negedge pclk);
        n++;
        run  = (ball_pos != prev) ? run + 1 : 0;
        prev = ball_pos;
      end
    end
  endtask

  task automatic click();
    mouse_left = 1'b1;
    @(negedge pclk);
    mouse_left = 1'b0;
  endtask

  // reference models advance on the same edge as the DUT
  always @(posedge pclk) begin
    if (rst) begin
      ref_ball       = '0;
      ref_ball.right = 1'b1;
      hc             = 0;
      vc             = 0;
      exp_rgb        = '0;
      exp_hsync      = 1'b0;
      exp_vsync      = 1'b0;
      armed          = 1'b1;
    end else begin
      exp_rgb   = pixel_color(hc, vc, ref_ball.x, ref_ball.y, mouse_ypos);
      exp_hsync = !(hc >= `H_VISIBLE + `H_FRONT && hc < `H_VISIBLE + `H_FRONT + `H_SYNC);
      exp_vsync = !(vc >= `V_VISIBLE + `V_FRONT && vc < `V_VISIBLE + `V_FRONT + `V_SYNC);
      if (exp_rgb == `COLOR_BALL) n_ball++;
      if (exp_rgb == `COLOR_RACKET) n_racket++;
      if (exp_rgb == `COLOR_NET) n_net++;
      hc++;
      if (hc == `H_TOTAL) begin
        hc = 0;
        vc = (vc == `V_TOTAL - 1) ? 0 : vc + 1;
      end
      ref_ball = next_ball(ref_ball, mouse_ypos, mouse_left, difficulty);
    end
  end

  always @(negedge pclk) begin
    if (armed) begin
      check_equal("ball_pos.xpos", ball_pos.xpos, ref_ball.x);
      check_equal("ball_pos.ypos", ball_pos.ypos, ref_ball.y);
      check_equal("rgb", rgb, exp_rgb);
      check_equal("hsync", hsync, exp_hsync);
      check_equal("vsync", vsync, exp_vsync);
    end
  end

  // racket follows the ball inside or well away from its span
  always @(negedge pclk) begin
    if (track_mode == 1) begin
      mouse_ypos = (ref_ball.y >= 30) ? ref_ball.y - 12'd30 : '0;
    end else if (track_mode == 2) begin
      mouse_ypos = (ref_ball.y < 384) ? ref_ball.y + 12'd200 : ref_ball.y - 12'd300;
    end
  end

  initial begin
    pclk       = 1'b0;
    rst        = 1'b1;
    mouse_left = 1'b0;
    difficulty = 1'b0;
    mouse_ypos = '0;
    armed      = 1'b0;
    track_mode = 0;
    seed       = 32'he5f8_cfb1;
    n_ball     = 0;
    n_racket   = 0;
    n_net      = 0;
    repeat (10) @(negedge pclk);
    rst = 1'b0;

    // idle ball follows the mouse one cycle later
    for (i = 0; i < 200; i++) begin
      y_set      = coord_t'($unsigned($random(seed)) % `V_VISIBLE);
      mouse_ypos = y_set;
      @(negedge pclk);
      check_equal("ball_pos.xpos", ball_pos.xpos, `CENTRAL_LINE);
      check_equal("ball_pos.ypos", ball_pos.ypos, y_set);
    end

    // one whole frame with the ball parked next to the net
    mouse_ypos = 12'd300;
    repeat (`H_TOTAL * `V_TOTAL + 16) @(negedge pclk);
    if (n_ball == 0 || n_racket == 0 || n_net == 0) begin
      report_failure("frame did not show ball, racket and net pixels");
    end

    // easy game across all four walls
    track_mode = 2;
    click();
    wait_until(sel_x, 0, wait_limit, "the ball at the left wall");
    wait_until(sel_x, `RIGHT_WALL - `BALL_DIAMETER + 1, wait_limit,
               "the ball at the right wall");
    wait_until(sel_y, 0, wait_limit, "the ball at the top wall");
    wait_until(sel_y, `DOWN_WALL - `BALL_DIAMETER + 1, wait_limit,
               "the ball at the bottom wall");

    // racket in the way and then out of the way
    wait_until(sel_x, `RIGHT_WALL - `BALL_DIAMETER + 1, wait_limit, "a right wall bounce");
    track_mode = 1;
    wait_until(sel_x, `RACKET_XPOS, wait_limit, "the ball at the racket column");
    wait_until(sel_x, `RACKET_XPOS + 1, 4 * start_interval, "a racket bounce");
    track_mode = 2;
    wait_until(sel_x, `RIGHT_WALL - `BALL_DIAMETER + 1, wait_limit, "a right wall bounce");
    wait_until(sel_x, `RACKET_XPOS, wait_limit, "the ball at the racket column");
    wait_until(sel_x, `RACKET_XPOS - 2, 4 * start_interval, "the ball passing the racket");

    // second click stops the game
    track_mode = 0;
    click();
    check_equal("ball_pos.xpos", ball_pos.xpos, `CENTRAL_LINE);
    check_equal("ball_pos.ypos", ball_pos.ypos, mouse_ypos);

    // hard game runs down to one step per cycle
    difficulty = 1'b1;
    track_mode = 2;
    @(negedge pclk);
    click();
    wait_until(sel_run, 3, wait_limit, "back to back ball steps");
    wait_until(sel_speed, `MAX_SPEED_STEPS, wait_limit, "the last speed step");
    repeat (5000) @(negedge pclk);
    track_mode = 0;
    click();
    check_equal("ball_pos.xpos", ball_pos.xpos, `CENTRAL_LINE);

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
design/pong_pkg.sv
design/ball_ctl.sv
design/vga_timing.sv
design/pixel_render.sv
design/pong_top.sv
sim/pong_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module pong_tb \
    -f flist.f --Mdir obj_dir -o pong_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/pong_sim 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1
